// File: src/exn_pkg.sv
package exn_pkg;

   // bundle geometry
   localparam int num_slots = 4;

   typedef logic [$clog2(num_slots)-1:0] slot_idx_t;

   // exception causes; noerr must stay zero
   typedef enum logic [4:0] {
      exn_noerr     = 5'd0,
      exn_interrupt = 5'd1,  // external, slot 0 only
      exn_inst_pf   = 5'd2,  // fetch page fault
      exn_ill       = 5'd3,  // illegal instruction
      exn_dup_dest  = 5'd4,  // two writes to one register
      exn_data_pf   = 5'd5,  // load/store page fault
      exn_divzero   = 5'd6,
      exn_syscall   = 5'd7,
      exn_break     = 5'd8
   } exn_code_t;

endpackage

// File: src/exn_stage_reg.sv
`timescale 1ns/1ps

module exn_stage_reg #(
   parameter int addr_w = 32
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          flush,
   input  logic                          in_valid,
   input  logic [addr_w-1:0]             in_pc,
   input  logic                          in_inst_pf,
   input  logic [exn_pkg::num_slots-1:0] in_invalid,
   input  logic                          in_dup_dest,
   input  logic                          in_data_pf0,
   input  logic                          in_data_pf1,
   input  logic                          in_div_zero,
   input  logic                          in_syscall,
   input  logic                          in_break,
   input  logic                          int_pending,
   output logic                          pc_valid,
   output logic [addr_w-1:0]             pc_pc,
   output logic                          pc_inst_pf,
   output logic [exn_pkg::num_slots-1:0] pc_invalid,
   output logic                          pc_dup_dest,
   output logic                          pc_data_pf0,
   output logic                          pc_data_pf1,
   output logic                          pc_div_zero,
   output logic                          pc_syscall,
   output logic                          pc_break,
   output logic                          pc_int_pending
);

   logic valid_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= in_valid;
      end
   end

   // flags ride along whatever the valid bit says
   always_ff @(posedge clk) begin
      pc_pc          <= in_pc;
      pc_inst_pf     <= in_inst_pf;
      pc_invalid     <= in_invalid;
      pc_dup_dest    <= in_dup_dest;
      pc_data_pf0    <= in_data_pf0;
      pc_data_pf1    <= in_data_pf1;
      pc_div_zero    <= in_div_zero;
      pc_syscall     <= in_syscall;
      pc_break       <= in_break;
      pc_int_pending <= int_pending;
   end

   // bundle behind a fault is dead while flush is up
   assign pc_valid = valid_q & ~flush;

   // a squashed stage cannot raise another fault
   flush_not_back_to_back: assert property (
      @(posedge clk) disable iff (reset)
      flush |=> !flush
   ) else $error("flush high two cycles in a row");

endmodule

// File: src/exn_encode.sv
`timescale 1ns/1ps

module exn_encode (
   input  logic                          pc_valid,
   input  logic                          pc_inst_pf,
   input  logic [exn_pkg::num_slots-1:0] pc_invalid,
   input  logic                          pc_dup_dest,
   input  logic                          pc_data_pf0,
   input  logic                          pc_data_pf1,
   input  logic                          pc_div_zero,
   input  logic                          pc_int_pending,
   input  logic                          pc_syscall,
   input  logic                          pc_break,
   input  logic                          interrupts_enabled,
   output exn_pkg::exn_code_t            combined_ec0,
   output exn_pkg::exn_code_t            combined_ec1,
   output exn_pkg::exn_code_t            combined_ec2,
   output exn_pkg::exn_code_t            combined_ec3,
   output logic                          exception
);

   // slot 0 carries interrupts and every fault kind
   always_comb begin
      combined_ec0 = exn_pkg::exn_noerr;
      if (pc_int_pending && interrupts_enabled)
         combined_ec0 = exn_pkg::exn_interrupt;  // any real fault overrides
      if (pc_inst_pf)
         combined_ec0 = exn_pkg::exn_inst_pf;
      else if (pc_invalid[0])
         combined_ec0 = exn_pkg::exn_ill;
      else if (pc_dup_dest)
         combined_ec0 = exn_pkg::exn_dup_dest;
      else if (pc_data_pf0)
         combined_ec0 = exn_pkg::exn_data_pf;
      else if (pc_div_zero)
         combined_ec0 = exn_pkg::exn_divzero;
      else if (pc_syscall)
         combined_ec0 = exn_pkg::exn_syscall;
      else if (pc_break)
         combined_ec0 = exn_pkg::exn_break;
   end

   always_comb begin
      combined_ec1 = exn_pkg::exn_noerr;
      if (pc_invalid[1])
         combined_ec1 = exn_pkg::exn_ill;
      else if (pc_data_pf1)
         combined_ec1 = exn_pkg::exn_data_pf;  // second memory port
   end

   assign combined_ec2 = pc_invalid[2] ? exn_pkg::exn_ill : exn_pkg::exn_noerr;
   assign combined_ec3 = pc_invalid[3] ? exn_pkg::exn_ill : exn_pkg::exn_noerr;

   // stale flags from an empty stage must never fault
   always_comb begin
      exception = pc_valid &
                  ((combined_ec0 != exn_pkg::exn_noerr) |
                   (combined_ec1 != exn_pkg::exn_noerr) |
                   (combined_ec2 != exn_pkg::exn_noerr) |
                   (combined_ec3 != exn_pkg::exn_noerr));
   end

endmodule

// File: src/exn_commit.sv
`timescale 1ns/1ps

module exn_commit #(
   parameter int addr_w = 32
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                exception,
   input  exn_pkg::exn_code_t  combined_ec0,
   input  exn_pkg::exn_code_t  combined_ec1,
   input  exn_pkg::exn_code_t  combined_ec2,
   input  exn_pkg::exn_code_t  combined_ec3,
   input  logic [addr_w-1:0]   pc_pc,
   input  logic                ie_set,
   input  logic                eret,
   output logic                flush,
   output exn_pkg::exn_code_t  exn_cause,
   output exn_pkg::slot_idx_t  exn_slot,
   output logic [addr_w-1:0]   exn_pc,
   output logic                interrupts_enabled
);

   exn_pkg::exn_code_t codes [exn_pkg::num_slots];
   exn_pkg::exn_code_t sel_code;
   exn_pkg::slot_idx_t sel_slot;
   logic               saved_ie;

   assign codes[0] = combined_ec0;
   assign codes[1] = combined_ec1;
   assign codes[2] = combined_ec2;
   assign codes[3] = combined_ec3;

   // scan from the top so the lowest faulting slot lands last
   always_comb begin
      sel_code = exn_pkg::exn_noerr;
      sel_slot = '0;
      for (int i = exn_pkg::num_slots - 1; i >= 0; i--) begin
         if (codes[i] != exn_pkg::exn_noerr) begin
            sel_code = codes[i];
            sel_slot = exn_pkg::slot_idx_t'(i);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         flush     <= 1'b0;
         exn_cause <= exn_pkg::exn_noerr;
         exn_slot  <= '0;
         exn_pc    <= '0;
      end else begin
         flush <= exception;  // single pulse, stage squashes behind it
         if (exception) begin
            exn_cause <= sel_code;
            exn_slot  <= sel_slot;
            exn_pc    <= pc_pc;
         end
      end
   end

   // exception beats eret, eret beats ie_set
   always_ff @(posedge clk) begin
      if (reset) begin
         interrupts_enabled <= 1'b0;
         saved_ie           <= 1'b0;
      end else if (exception) begin
         saved_ie           <= interrupts_enabled;
         interrupts_enabled <= 1'b0;  // handler starts masked
      end else if (eret) begin
         interrupts_enabled <= saved_ie;
      end else if (ie_set) begin
         interrupts_enabled <= 1'b1;
      end
   end

   flush_has_cause: assert property (
      @(posedge clk) disable iff (reset)
      flush |-> exn_cause != exn_pkg::exn_noerr
   ) else $error("flush committed with no cause");

endmodule

// File: src/exn_unit.sv
`timescale 1ns/1ps

module exn_unit #(
   parameter int addr_w = 32
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          in_valid,
   input  logic [addr_w-1:0]             in_pc,
   input  logic                          in_inst_pf,
   input  logic [exn_pkg::num_slots-1:0] in_invalid,
   input  logic                          in_dup_dest,
   input  logic                          in_data_pf0,
   input  logic                          in_data_pf1,
   input  logic                          in_div_zero,
   input  logic                          in_syscall,
   input  logic                          in_break,
   input  logic                          int_pending,
   input  logic                          ie_set,
   input  logic                          eret,
   output logic                          flush,
   output exn_pkg::exn_code_t            exn_cause,
   output exn_pkg::slot_idx_t            exn_slot,
   output logic [addr_w-1:0]             exn_pc,
   output logic                          interrupts_enabled
);

   logic                          pc_valid;
   logic [addr_w-1:0]             pc_pc;
   logic                          pc_inst_pf;
   logic [exn_pkg::num_slots-1:0] pc_invalid;
   logic                          pc_dup_dest;
   logic                          pc_data_pf0;
   logic                          pc_data_pf1;
   logic                          pc_div_zero;
   logic                          pc_syscall;
   logic                          pc_break;
   logic                          pc_int_pending;
   exn_pkg::exn_code_t            combined_ec0;
   exn_pkg::exn_code_t            combined_ec1;
   exn_pkg::exn_code_t            combined_ec2;
   exn_pkg::exn_code_t            combined_ec3;
   logic                          exception;

   exn_stage_reg #(.addr_w(addr_w)) u_stage (
      .clk, .reset, .flush,
      .in_valid, .in_pc, .in_inst_pf, .in_invalid, .in_dup_dest,
      .in_data_pf0, .in_data_pf1, .in_div_zero, .in_syscall, .in_break,
      .int_pending,
      .pc_valid, .pc_pc, .pc_inst_pf, .pc_invalid, .pc_dup_dest,
      .pc_data_pf0, .pc_data_pf1, .pc_div_zero, .pc_syscall, .pc_break,
      .pc_int_pending
   );

   exn_encode u_encode (
      .pc_valid, .pc_inst_pf, .pc_invalid, .pc_dup_dest,
      .pc_data_pf0, .pc_data_pf1, .pc_div_zero, .pc_int_pending,
      .pc_syscall, .pc_break, .interrupts_enabled,
      .combined_ec0, .combined_ec1, .combined_ec2, .combined_ec3,
      .exception
   );

   exn_commit #(.addr_w(addr_w)) u_commit (
      .clk, .reset, .exception,
      .combined_ec0, .combined_ec1, .combined_ec2, .combined_ec3,
      .pc_pc, .ie_set, .eret,
      .flush, .exn_cause, .exn_slot, .exn_pc, .interrupts_enabled
   );

endmodule

// File: bench/exn_unit_tb.sv
`timescale 1ns/1ps

module exn_unit_tb;

   localparam int addr_w       = 32;
   localparam int reset_len    = 2;
   localparam int directed_len = 53;
   localparam int random_len   = 2000;
   localparam int max_cycles   = reset_len + directed_len + random_len + 50;

   // flag vector: inst_pf, invalid[3:0], dup_dest, data_pf0, data_pf1, div_zero, syscall, break
   localparam logic [10:0] f_inst_pf = 11'h400;
   localparam logic [10:0] f_ill0    = 11'h040;
   localparam logic [10:0] f_ill1    = 11'h080;
   localparam logic [10:0] f_ill2    = 11'h100;
   localparam logic [10:0] f_ill3    = 11'h200;
   localparam logic [10:0] f_dup     = 11'h020;
   localparam logic [10:0] f_dpf0    = 11'h010;
   localparam logic [10:0] f_dpf1    = 11'h008;
   localparam logic [10:0] f_divz    = 11'h004;
   localparam logic [10:0] f_sys     = 11'h002;
   localparam logic [10:0] f_brk     = 11'h001;

   logic                          clk = 1'b0;
   logic                          reset;
   logic                          in_valid;
   logic [addr_w-1:0]             in_pc;
   logic                          in_inst_pf;
   logic [exn_pkg::num_slots-1:0] in_invalid;
   logic                          in_dup_dest;
   logic                          in_data_pf0;
   logic                          in_data_pf1;
   logic                          in_div_zero;
   logic                          in_syscall;
   logic                          in_break;
   logic                          int_pending;
   logic                          ie_set;
   logic                          eret;
   logic                          flush;
   exn_pkg::exn_code_t            exn_cause;
   exn_pkg::slot_idx_t            exn_slot;
   logic [addr_w-1:0]             exn_pc;
   logic                          interrupts_enabled;

   // model of stage and commit state
   logic                          m_vq = 1'b0;
   logic [addr_w-1:0]             m_stage_pc = '0;
   logic [10:0]                   m_f = '0;
   logic                          m_int = 1'b0;
   logic                          m_flush = 1'b0;
   exn_pkg::exn_code_t            m_cause = exn_pkg::exn_noerr;
   exn_pkg::slot_idx_t            m_slot = '0;
   logic [addr_w-1:0]             m_pc = '0;
   logic                          m_ie = 1'b0;
   logic                          m_saved = 1'b0;

   logic [31:0] lfsr = 32'h37418433;
   int          code_errs = 0;
   int          slot_errs = 0;
   int          pc_errs = 0;
   int          bit_errs = 0;
   int          cycle_cnt = 0;

   exn_unit #(.addr_w(addr_w)) dut (
      .clk, .reset, .in_valid, .in_pc, .in_inst_pf, .in_invalid, .in_dup_dest,
      .in_data_pf0, .in_data_pf1, .in_div_zero, .in_syscall, .in_break,
      .int_pending, .ie_set, .eret,
      .flush, .exn_cause, .exn_slot, .exn_pc, .interrupts_enabled
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > max_cycles) begin
         $display("timeout: run went past %0d cycles", max_cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   function automatic logic rand_bit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32,22,2,1
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
         r = {r[30:0], rand_bit()};
      return r;
   endfunction

   function automatic exn_pkg::exn_code_t expect_code(input int slot, input logic [10:0] f,
                                                      input logic intp, input logic ie);
      exn_pkg::exn_code_t c;
      c = exn_pkg::exn_noerr;
      case (slot)
         0: begin
            if (f[10]) c = exn_pkg::exn_inst_pf;
            else if (f[6]) c = exn_pkg::exn_ill;
            else if (f[5]) c = exn_pkg::exn_dup_dest;
            else if (f[4]) c = exn_pkg::exn_data_pf;
            else if (f[2]) c = exn_pkg::exn_divzero;
            else if (f[1]) c = exn_pkg::exn_syscall;
            else if (f[0]) c = exn_pkg::exn_break;
            else if (intp && ie) c = exn_pkg::exn_interrupt;  // only when no real fault
         end
         1: begin
            if (f[7]) c = exn_pkg::exn_ill;
            else if (f[3]) c = exn_pkg::exn_data_pf;
         end
         2: if (f[8]) c = exn_pkg::exn_ill;
         3: if (f[9]) c = exn_pkg::exn_ill;
         default: c = exn_pkg::exn_noerr;
      endcase
      return c;
   endfunction

   task automatic check_code(input string name, input exn_pkg::exn_code_t exp, act);
      if (act !== exp) begin
         code_errs++;
         $display("error %s: expected %s got %s", name, exp.name(), act.name());
      end
   endtask

   task automatic check_slot(input string name, input exn_pkg::slot_idx_t exp, act);
      if (act !== exp) begin
         slot_errs++;
         $display("error %s: expected %0d got %0d", name, exp, act);
      end
   endtask

   task automatic check_pc(input string name, input logic [addr_w-1:0] exp, act);
      if (act !== exp) begin
         pc_errs++;
         $display("error %s: expected %h got %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, act);
      if (act !== exp) begin
         bit_errs++;
         $display("error %s: expected %b got %b", name, exp, act);
      end
   endtask

   task automatic compare_all(input string name);
      check_bit({name, " flush"}, m_flush, flush);
      check_code({name, " cause"}, m_cause, exn_cause);
      check_slot({name, " slot"}, m_slot, exn_slot);
      check_pc({name, " pc"}, m_pc, exn_pc);
      check_bit({name, " ie"}, m_ie, interrupts_enabled);
   endtask

   // advance the model over the coming rising edge
   task automatic model_step();
      logic               exc;
      exn_pkg::exn_code_t c;
      exn_pkg::exn_code_t sel;
      exn_pkg::slot_idx_t sel_slot;
      sel = exn_pkg::exn_noerr;
      sel_slot = '0;
      for (int i = 0; i < exn_pkg::num_slots; i++) begin
         c = expect_code(i, m_f, m_int, m_ie);
         if (sel == exn_pkg::exn_noerr && c != exn_pkg::exn_noerr) begin
            sel = c;
            sel_slot = exn_pkg::slot_idx_t'(i);
         end
      end
      exc = m_vq && !m_flush && (sel != exn_pkg::exn_noerr);  // flush squashes stage
      if (reset) begin
         m_flush = 1'b0;
         m_cause = exn_pkg::exn_noerr;
         m_slot = '0;
         m_pc = '0;
         m_ie = 1'b0;
         m_saved = 1'b0;
      end else begin
         m_flush = exc;
         if (exc) begin
            m_cause = sel;
            m_slot = sel_slot;
            m_pc = m_stage_pc;
            m_saved = m_ie;
            m_ie = 1'b0;
         end else if (eret) begin
            m_ie = m_saved;
         end else if (ie_set) begin
            m_ie = 1'b1;
         end
      end
      m_vq = !reset && in_valid;
      m_stage_pc = in_pc;
      m_f = {in_inst_pf, in_invalid, in_dup_dest, in_data_pf0, in_data_pf1,
             in_div_zero, in_syscall, in_break};
      m_int = int_pending;
   endtask

   task automatic run_cycle(input string name);
      model_step();
      @(negedge clk);
      compare_all(name);
   endtask

   task automatic apply_flags(input logic [10:0] f);
      in_inst_pf = f[10];
      in_invalid = f[9:6];
      in_dup_dest = f[5];
      in_data_pf0 = f[4];
      in_data_pf1 = f[3];
      in_div_zero = f[2];
      in_syscall = f[1];
      in_break = f[0];
   endtask

   task automatic clear_inputs();
      in_valid = 1'b0;
      in_pc = '0;
      int_pending = 1'b0;
      apply_flags(11'h000);
   endtask

   task automatic drive_bundle(input logic [addr_w-1:0] pc, input logic intp,
                               input logic [10:0] f);
      in_valid = 1'b1;
      in_pc = pc;
      int_pending = intp;
      apply_flags(f);
   endtask

   task automatic pulse_ie(input logic set, input logic ret);
      ie_set = set;
      eret = ret;
      run_cycle("ie pulse");
      ie_set = 1'b0;
      eret = 1'b0;
   endtask

   // one faulting bundle, checked at its flush, then one idle cycle
   task automatic fault_test(input string name, input logic [addr_w-1:0] pc, input logic intp,
                             input logic [10:0] f, input exn_pkg::exn_code_t code,
                             input exn_pkg::slot_idx_t slot);
      drive_bundle(pc, intp, f);
      run_cycle(name);
      clear_inputs();
      run_cycle(name);
      check_bit({name, " flush"}, 1'b1, flush);
      check_code({name, " cause"}, code, exn_cause);
      check_slot({name, " slot"}, slot, exn_slot);
      check_pc({name, " pc"}, pc, exn_pc);
      run_cycle(name);
   endtask

   initial begin
      reset = 1'b1;
      ie_set = 1'b0;
      eret = 1'b0;
      clear_inputs();
      repeat (reset_len) run_cycle("reset");
      reset = 1'b0;
      check_bit("reset flush", 1'b0, flush);
      check_bit("reset ie", 1'b0, interrupts_enabled);
      check_code("reset cause", exn_pkg::exn_noerr, exn_cause);

      pulse_ie(1'b1, 1'b0);
      fault_test("prio inst_pf", 32'h0000_0100, 1'b1, f_inst_pf | f_ill0 | f_dup,
                 exn_pkg::exn_inst_pf, 2'd0);
      pulse_ie(1'b0, 1'b1);
      fault_test("prio dup", 32'h0000_0110, 1'b1, f_dup | f_divz | f_brk,
                 exn_pkg::exn_dup_dest, 2'd0);
      pulse_ie(1'b0, 1'b1);
      fault_test("prio syscall", 32'h0000_0120, 1'b0, f_sys | f_brk, exn_pkg::exn_syscall, 2'd0);
      pulse_ie(1'b0, 1'b1);
      fault_test("prio data_pf0", 32'h0000_0130, 1'b0, f_dpf0 | f_divz,
                 exn_pkg::exn_data_pf, 2'd0);
      pulse_ie(1'b0, 1'b1);
      fault_test("interrupt", 32'h0000_0140, 1'b1, 11'h000, exn_pkg::exn_interrupt, 2'd0);
      drive_bundle(32'h0000_0150, 1'b1, 11'h000);  // enable now clear
      run_cycle("int masked");
      clear_inputs();
      run_cycle("int masked");
      check_bit("int masked flush", 1'b0, flush);

      fault_test("slot1 data_pf", 32'h0000_0200, 1'b0, f_ill3 | f_dpf1 | f_ill2,
                 exn_pkg::exn_data_pf, 2'd1);
      fault_test("slot2 ill", 32'h0000_0210, 1'b0, f_ill2 | f_ill3, exn_pkg::exn_ill, 2'd2);
      fault_test("slot1 ill", 32'h0000_0220, 1'b0, f_ill1 | f_dpf1, exn_pkg::exn_ill, 2'd1);
      fault_test("slot3 ill", 32'h0000_0230, 1'b0, f_ill3, exn_pkg::exn_ill, 2'd3);

      drive_bundle(32'h0000_1000, 1'b0, f_ill0);
      run_cycle("squash");
      drive_bundle(32'h0000_2000, 1'b0, f_ill2);  // follows the fault
      run_cycle("squash");
      check_bit("squash flush", 1'b1, flush);
      check_pc("squash pc", 32'h0000_1000, exn_pc);
      clear_inputs();
      run_cycle("squash");
      check_bit("squash next", 1'b0, flush);
      run_cycle("squash");
      check_pc("squash kept", 32'h0000_1000, exn_pc);
      apply_flags(11'h7ff);
      int_pending = 1'b1;
      run_cycle("invalid bundle");
      clear_inputs();
      run_cycle("invalid bundle");
      check_bit("invalid bundle flush", 1'b0, flush);

      pulse_ie(1'b1, 1'b0);
      check_bit("ie_set", 1'b1, interrupts_enabled);
      fault_test("ie clear", 32'h0000_0300, 1'b0, f_brk, exn_pkg::exn_break, 2'd0);
      check_bit("ie clear", 1'b0, interrupts_enabled);
      pulse_ie(1'b0, 1'b1);
      check_bit("eret restore", 1'b1, interrupts_enabled);
      drive_bundle(32'h0000_0310, 1'b0, f_ill2);
      run_cycle("ie race");
      clear_inputs();
      ie_set = 1'b1;
      eret = 1'b1;
      run_cycle("ie race");
      check_bit("exception beats ie_set", 1'b0, interrupts_enabled);
      ie_set = 1'b0;
      eret = 1'b0;
      run_cycle("ie race");
      fault_test("ie saved low", 32'h0000_0320, 1'b0, f_divz, exn_pkg::exn_divzero, 2'd0);
      pulse_ie(1'b0, 1'b1);
      check_bit("eret restores low", 1'b0, interrupts_enabled);
      pulse_ie(1'b1, 1'b0);

      for (int n = 0; n < random_len; n++) begin
         in_valid = (rand_bits(2) != 32'd0);  // about 3 in 4
         in_pc = rand_bits(32);
         in_inst_pf = (rand_bits(3) == 32'd7);
         for (int s = 0; s < exn_pkg::num_slots; s++)
            in_invalid[s] = (rand_bits(3) == 32'd7);
         in_dup_dest = (rand_bits(3) == 32'd7);
         in_data_pf0 = (rand_bits(3) == 32'd7);
         in_data_pf1 = (rand_bits(3) == 32'd7);
         in_div_zero = (rand_bits(3) == 32'd7);
         in_syscall = (rand_bits(3) == 32'd7);
         in_break = (rand_bits(3) == 32'd7);
         int_pending = (rand_bits(2) == 32'd3);
         ie_set = (rand_bits(3) == 32'd7);
         eret = (rand_bits(3) == 32'd7);
         run_cycle("random");
      end

      $display("errors: code %0d slot %0d pc %0d bit %0d", code_errs, slot_errs, pc_errs,
               bit_errs);
      if (code_errs + slot_errs + pc_errs + bit_errs == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: flist.f
src/exn_pkg.sv
src/exn_stage_reg.sv
src/exn_encode.sv
src/exn_commit.sv
src/exn_unit.sv
bench/exn_unit_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module exn_unit_tb -o exn_sim
./obj_dir/exn_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
